// File: src/gpio_defines.svh
`ifndef GPIO_DEFINES_SVH
`define GPIO_DEFINES_SVH

// ------------------------------
// widths
// ------------------------------
`define GPIO_WIDTH 16                // pins and data word
`define GPIO_AW    6                 // register byte address

// ------------------------------
// register byte offsets
// ------------------------------
`define GPR_DIRECTION_MODE  6'h04    // 1 = input, 0 = output
`define GPR_OUTPUT_ENABLE   6'h08    // per-pin driver enable
`define GPR_OUTPUT_VALUE    6'h0C    // value driven on pin_out
`define GPR_INPUT_VALUE     6'h10    // synchronized pin value, read only
`define GPR_INT_STATUS      6'h20    // rising edge status, clear on read

// ------------------------------
// reset values
// ------------------------------
`define GPRV_DIRECTION_MODE 16'h0000 // all pins output
`define GPRV_OUTPUT_ENABLE  16'h0000 // drivers off after reset
`define GPRV_OUTPUT_VALUE   16'h0000
`define GPRV_INPUT_VALUE    16'h0000
`define GPRV_INT_STATUS     16'h0000 // no pending interrupts

`endif

// File: src/gpio_pkg.sv
`include "gpio_defines.svh"

package gpio_pkg;

  // data word, also one bit per pin
  typedef logic [`GPIO_WIDTH-1:0] gpio_word_t;

  // register byte address
  typedef logic [`GPIO_AW-1:0] gpio_addr_t;

  // wishbone slave states
  typedef enum logic [1:0]
  {
    BUS_IDLE = 2'd0,  // waiting for cyc & stb
    BUS_ACK  = 2'd1,  // ack high for one cycle
    BUS_WAIT = 2'd2   // master still holds stb
  } bus_state_t;

endpackage

// File: src/gpio_pin_unit.sv
`timescale 1ns/100ps
`include "gpio_defines.svh"

module gpio_pin_unit
(
  input  logic                pclk30,
  input  logic                n_reset30,        // async, active low
  input  logic                read,             // one-cycle read strobe
  input  logic                write,            // one-cycle write strobe
  input  gpio_pkg::gpio_addr_t addr,
  input  gpio_pkg::gpio_word_t wdata,
  input  gpio_pkg::gpio_word_t pin_in,          // raw pin values, async
  input  gpio_pkg::gpio_word_t tri_state_enable, // test input, forces Z
  output gpio_pkg::gpio_word_t rdata,
  output gpio_pkg::gpio_word_t interrupt,
  output gpio_pkg::gpio_word_t pin_out,
  output gpio_pkg::gpio_word_t pin_oe_n
);

  import gpio_pkg::*;

  // ------------------------------
  // registers
  // ------------------------------
  gpio_word_t direction_mode;   // 1 = input, 0 = output
  gpio_word_t output_enable;    // driver on where 1
  gpio_word_t output_value;     // driven value
  gpio_word_t input_value;      // third sync stage, readable
  gpio_word_t int_status;       // sticky rising edge flags

  gpio_word_t sync_one;         // first stage, next to the pins
  gpio_word_t sync_two;         // second stage

  // address decode
  logic       ad_direction_mode;
  logic       ad_output_enable;
  logic       ad_output_value;
  logic       ad_int_status;

  // interrupt helpers
  logic       status_clear;     // read of status clears all bits
  gpio_word_t int_event;        // synchronized value rose
  gpio_word_t int_trigger;      // rising edge on an input-mode pin

  assign ad_direction_mode = (addr == `GPR_DIRECTION_MODE);
  assign ad_output_enable  = (addr == `GPR_OUTPUT_ENABLE);
  assign ad_output_value   = (addr == `GPR_OUTPUT_VALUE);
  assign ad_int_status     = (addr == `GPR_INT_STATUS);

  // ------------------------------
  // control register writes
  // ------------------------------
  always_ff @(posedge pclk30 or negedge n_reset30)
  begin
    if (!n_reset30)
    begin
      direction_mode <= `GPRV_DIRECTION_MODE;
      output_enable  <= `GPRV_OUTPUT_ENABLE;
      output_value   <= `GPRV_OUTPUT_VALUE;
    end
    else if (write)
    begin
      if (ad_direction_mode)
      begin
        direction_mode <= wdata;
      end
      if (ad_output_enable)
      begin
        output_enable <= wdata;
      end
      if (ad_output_value)
      begin
        output_value <= wdata;
      end
      // writes to input value and status are ignored
    end
  end

  // ------------------------------
  // input synchronizer
  // ------------------------------
  // pin change shows in input_value three edges after sampling
  always_ff @(posedge pclk30 or negedge n_reset30)
  begin
    if (!n_reset30)
    begin
      sync_one    <= '0;
      sync_two    <= '0;
      input_value <= `GPRV_INPUT_VALUE;
    end
    else
    begin
      sync_one    <= pin_in;      // may go metastable
      sync_two    <= sync_one;
      input_value <= sync_two;    // settled value
    end
  end

  // ------------------------------
  // interrupt status
  // ------------------------------
  // rising edge seen as new value high, old value still low
  assign int_event    = sync_two & ~input_value;
  assign int_trigger  = int_event & direction_mode;  // input mode only
  assign status_clear = read & ad_int_status;

  always_ff @(posedge pclk30 or negedge n_reset30)
  begin
    if (!n_reset30)
    begin
      int_status <= `GPRV_INT_STATUS;
    end
    else
    begin
      // trigger wins over a clear in the same cycle
      int_status <= (int_status & ~{$bits(gpio_word_t){status_clear}}) | int_trigger;
    end
  end

  assign interrupt = int_status;  // one line per pin, no combining

  // ------------------------------
  // read data
  // ------------------------------
  always_ff @(posedge pclk30 or negedge n_reset30)
  begin
    if (!n_reset30)
    begin
      rdata <= '0;
    end
    else if (read)
    begin
      case (addr)
        `GPR_DIRECTION_MODE: rdata <= direction_mode;
        `GPR_OUTPUT_ENABLE:  rdata <= output_enable;
        `GPR_OUTPUT_VALUE:   rdata <= output_value;
        `GPR_INT_STATUS:     rdata <= int_status;  // value before clear
        default:             rdata <= input_value; // input value or unmapped
      endcase
    end
    else
    begin
      rdata <= '0;   // zero outside read cycles
    end
  end

  // ------------------------------
  // pin drivers
  // ------------------------------
  assign pin_out = output_value;

  // driver on only if enabled, output mode and not in test tri-state
  assign pin_oe_n = ~(output_enable & ~direction_mode) | tri_state_enable;

endmodule

// File: src/gpio_bus_fsm.sv
`timescale 1ns/100ps

module gpio_bus_fsm
(
  input  logic                pclk30,
  input  logic                n_reset30,  // async, active low
  input  logic                cyc,        // wishbone cycle
  input  logic                stb,        // wishbone strobe
  input  logic                we,         // 1 = write
  input  gpio_pkg::gpio_addr_t adr,
  input  gpio_pkg::gpio_word_t dat_w,
  output logic                ack,
  output logic                read,       // one-cycle strobe to pin unit
  output logic                write,      // one-cycle strobe to pin unit
  output gpio_pkg::gpio_addr_t addr,
  output gpio_pkg::gpio_word_t wdata
);

  import gpio_pkg::*;

  bus_state_t state;
  bus_state_t state_nxt;
  logic       req;        // qualified request in idle

  // master holds adr and dat_w until ack, so pass straight on
  assign addr  = adr;
  assign wdata = dat_w;

  // new access only from idle
  assign req   = cyc & stb & (state == BUS_IDLE);
  assign read  = req & ~we;
  assign write = req & we;
  assign ack   = (state == BUS_ACK);   // second cycle of the request

  // ------------------------------
  // next state
  // ------------------------------
  always_comb
  begin
    state_nxt = state;
    case (state)
      BUS_IDLE:
      begin
        if (req)
        begin
          state_nxt = BUS_ACK;
        end
      end
      BUS_ACK:
      begin
        // held stb must not start another access
        state_nxt = stb ? BUS_WAIT : BUS_IDLE;
      end
      BUS_WAIT:
      begin
        if (!stb)
        begin
          state_nxt = BUS_IDLE;
        end
      end
      default: state_nxt = BUS_IDLE;   // unused encoding
    endcase
  end

  always_ff @(posedge pclk30 or negedge n_reset30)
  begin
    if (!n_reset30)
    begin
      state <= BUS_IDLE;
    end
    else
    begin
      state <= state_nxt;
    end
  end

endmodule

// File: src/gpio_top.sv
`timescale 1ns/100ps

module gpio_top
(
  input  logic                pclk30,
  input  logic                n_reset30,        // async, active low

  // wishbone classic slave
  input  logic                cyc,
  input  logic                stb,
  input  logic                we,
  input  gpio_pkg::gpio_addr_t adr,
  input  gpio_pkg::gpio_word_t dat_w,
  output gpio_pkg::gpio_word_t dat_r,
  output logic                ack,

  // pins
  input  gpio_pkg::gpio_word_t pin_in,
  input  gpio_pkg::gpio_word_t tri_state_enable, // test, all drivers to Z
  output gpio_pkg::gpio_word_t pin_out,
  output gpio_pkg::gpio_word_t pin_oe_n,
  output gpio_pkg::gpio_word_t interrupt         // one bit per pin
);

  import gpio_pkg::*;

  // ------------------------------
  // bus fsm to pin unit
  // ------------------------------
  logic       bus_read;
  logic       bus_write;
  gpio_addr_t bus_addr;
  gpio_word_t bus_wdata;

  gpio_bus_fsm u_bus_fsm
  (
    .pclk30    (pclk30),
    .n_reset30 (n_reset30),
    .cyc       (cyc),
    .stb       (stb),
    .we        (we),
    .adr       (adr),
    .dat_w     (dat_w),
    .ack       (ack),
    .read      (bus_read),
    .write     (bus_write),
    .addr      (bus_addr),
    .wdata     (bus_wdata)
  );

  // rdata is registered inside, valid while ack is high
  gpio_pin_unit u_pin_unit
  (
    .pclk30           (pclk30),
    .n_reset30        (n_reset30),
    .read             (bus_read),
    .write            (bus_write),
    .addr             (bus_addr),
    .wdata            (bus_wdata),
    .pin_in           (pin_in),
    .tri_state_enable (tri_state_enable),
    .rdata            (dat_r),
    .interrupt        (interrupt),
    .pin_out          (pin_out),
    .pin_oe_n         (pin_oe_n)
  );

endmodule

// File: bench/tb_gpio.sv
`timescale 1ns/100ps
`include "gpio_defines.svh"

module tb_gpio;

  import gpio_pkg::*;

  // ------------------------------
  // run length
  // ------------------------------
  localparam int CLK_PERIOD    = 10;
  localparam int MAX_ACCESSES  = 80;   // upper bound over all tests
  localparam int ACCESS_CYCLES = 4;    // request, ack, drop, spare
  localparam int WAIT_CYCLES   = 80;   // reset, synchronizer and pin settling
  localparam int WATCHDOG_NS   = (MAX_ACCESSES * ACCESS_CYCLES + WAIT_CYCLES) * CLK_PERIOD * 10;
  localparam int ACK_TIMEOUT   = 8;    // cycles before giving up on ack

  logic        pclk30;
  logic        n_reset30;
  logic        cyc;
  logic        stb;
  logic        we;
  gpio_addr_t  adr;
  gpio_word_t  dat_w;
  gpio_word_t  dat_r;
  logic        ack;
  gpio_word_t  pin_in;
  gpio_word_t  tri_state_enable;
  gpio_word_t  pin_out;
  gpio_word_t  pin_oe_n;
  gpio_word_t  interrupt;

  logic [31:0] rng_state;        // xorshift state
  int          value_errors;
  int          protocol_errors;
  gpio_word_t  model_dir;        // expected register contents
  gpio_word_t  model_oe;
  gpio_word_t  model_ov;

  gpio_top u_gpio_top
  (
    .pclk30           (pclk30),
    .n_reset30        (n_reset30),
    .cyc              (cyc),
    .stb              (stb),
    .we               (we),
    .adr              (adr),
    .dat_w            (dat_w),
    .dat_r            (dat_r),
    .ack              (ack),
    .pin_in           (pin_in),
    .tri_state_enable (tri_state_enable),
    .pin_out          (pin_out),
    .pin_oe_n         (pin_oe_n),
    .interrupt        (interrupt)
  );

  always #(CLK_PERIOD / 2) pclk30 = ~pclk30;

  // ------------------------------
  // helpers
  // ------------------------------
  task automatic value_mismatch(input string name, input gpio_word_t exp, input gpio_word_t act);
    value_errors++;
    $display("FAIL %0t ns %s expected %h got %h", $time, name, exp, act);
  endtask

  task automatic protocol_error(input string what);
    protocol_errors++;
    $display("ERROR %0t ns %s", $time, what);
  endtask

  function automatic gpio_word_t rand_word();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state[`GPIO_WIDTH-1:0];
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge pclk30);
  endtask

  // one wishbone classic access, starts and ends on a falling edge
  task automatic bus_access(input logic write_en, input gpio_addr_t a, input gpio_word_t d,
                            input int hold, output gpio_word_t rd);
    int waited;
    waited = 0;
    cyc    = 1'b1;
    stb    = 1'b1;
    we     = write_en;
    adr    = a;
    dat_w  = d;
    @(negedge pclk30);
    waited = 1;
    while (!ack && waited < ACK_TIMEOUT)
    begin
      @(negedge pclk30);
      waited++;
    end
    rd = dat_r;                  // valid while ack is high
    if (!ack)
    begin
      protocol_error($sformatf("no ack for access to address %h", a));
    end
    else
    begin
      assert (waited == 1)
        else protocol_error($sformatf("ack came after %0d cycles instead of 1", waited));
    end
    if (hold > 0)
    begin
      dat_w = ~d;                // a retriggered write would store this
      repeat (hold)
      begin
        @(negedge pclk30);
        assert (!ack)
          else protocol_error("second ack while stb was held");
      end
    end
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
    @(negedge pclk30);
    assert (!ack)
      else protocol_error("ack still high after stb dropped");
  endtask

  task automatic write_reg(input gpio_addr_t a, input gpio_word_t d);
    gpio_word_t unused;
    bus_access(1'b1, a, d, 0, unused);
  endtask

  task automatic expect_reg(input gpio_addr_t a, input gpio_word_t exp, input string name);
    gpio_word_t rd;
    bus_access(1'b0, a, '0, 0, rd);
    assert (rd == exp)
      else value_mismatch(name, exp, rd);
  endtask

  // driver low only for enabled output-mode pins outside tri-state test
  task automatic check_pins();
    gpio_word_t exp_oe_n;
    exp_oe_n = ~(model_oe & ~model_dir & ~tri_state_enable);
    assert (pin_out == model_ov)
      else value_mismatch("pin_out", model_ov, pin_out);
    assert (pin_oe_n == exp_oe_n)
      else value_mismatch("pin_oe_n", exp_oe_n, pin_oe_n);
  endtask

  // ------------------------------
  // protocol assertions
  // ------------------------------
  ack_in_reset: assert property (@(posedge pclk30) !n_reset30 |-> !ack)
    else protocol_error("ack high during reset");

  ack_one_cycle: assert property (@(posedge pclk30) disable iff (!n_reset30) ack |=> !ack)
    else protocol_error("ack high for more than one cycle");

  // ------------------------------
  // watchdog
  // ------------------------------
  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
    $display("Regression failed");
    $finish;
  end

  // ------------------------------
  // stimulus
  // ------------------------------
  initial
  begin
    int         round;
    int         k;
    gpio_word_t rise;
    gpio_word_t rd;
    pclk30           = 1'b0;
    n_reset30        = 1'b0;
    cyc              = 1'b0;
    stb              = 1'b0;
    we               = 1'b0;
    adr              = '0;
    dat_w            = '0;
    pin_in           = '0;
    tri_state_enable = '0;
    rng_state        = 32'd70128;
    value_errors     = 0;
    protocol_errors  = 0;
    model_dir        = `GPRV_DIRECTION_MODE;
    model_oe         = `GPRV_OUTPUT_ENABLE;
    model_ov         = `GPRV_OUTPUT_VALUE;

    repeat (5)
    begin
      @(negedge pclk30);
      assert (!ack)
        else protocol_error("ack high during reset");
      assert (dat_r == '0)
        else value_mismatch("dat_r", '0, dat_r);
    end
    n_reset30 = 1'b1;

    // reset values
    expect_reg(`GPR_DIRECTION_MODE, `GPRV_DIRECTION_MODE, "dat_r direction_mode");
    expect_reg(`GPR_OUTPUT_ENABLE, `GPRV_OUTPUT_ENABLE, "dat_r output_enable");
    expect_reg(`GPR_OUTPUT_VALUE, `GPRV_OUTPUT_VALUE, "dat_r output_value");
    expect_reg(`GPR_INPUT_VALUE, `GPRV_INPUT_VALUE, "dat_r input_value");
    expect_reg(`GPR_INT_STATUS, `GPRV_INT_STATUS, "dat_r int_status");

    // read-back and pin drive
    for (round = 0; round < 6; round++)
    begin
      model_dir = rand_word();
      write_reg(`GPR_DIRECTION_MODE, model_dir);
      check_pins();
      model_oe = rand_word();
      write_reg(`GPR_OUTPUT_ENABLE, model_oe);
      check_pins();
      model_ov = rand_word();
      write_reg(`GPR_OUTPUT_VALUE, model_ov);
      check_pins();
      for (k = 0; k < 2; k++)
      begin
        tri_state_enable = rand_word();
        wait_cycles(1);          // let the comb outputs settle
        check_pins();
      end
      tri_state_enable = '0;
      expect_reg(`GPR_DIRECTION_MODE, model_dir, "dat_r direction_mode");
      expect_reg(`GPR_OUTPUT_ENABLE, model_oe, "dat_r output_enable");
      expect_reg(`GPR_OUTPUT_VALUE, model_ov, "dat_r output_value");
    end

    // input path, 3 edges of sync then read
    for (round = 0; round < 4; round++)
    begin
      pin_in = rand_word();
      wait_cycles(4);
      expect_reg(`GPR_INPUT_VALUE, pin_in, "dat_r input_value");
      expect_reg(6'h3C, pin_in, "dat_r unmapped");
    end

    // ------------------------------
    // interrupts
    // ------------------------------
    for (round = 0; round < 3; round++)
    begin
      model_dir = rand_word();
      write_reg(`GPR_DIRECTION_MODE, model_dir);
      pin_in = '0;
      wait_cycles(5);
      bus_access(1'b0, `GPR_INT_STATUS, '0, 0, rd);   // drop stale status
      assert (interrupt == '0)
        else value_mismatch("interrupt", '0, interrupt);
      rise   = rand_word();
      pin_in = rise;
      wait_cycles(5);
      assert (interrupt == (rise & model_dir))
        else value_mismatch("interrupt", rise & model_dir, interrupt);
      wait_cycles(3);            // sticky until read
      assert (interrupt == (rise & model_dir))
        else value_mismatch("interrupt", rise & model_dir, interrupt);
      expect_reg(`GPR_INT_STATUS, rise & model_dir, "dat_r int_status");
      assert (interrupt == '0)
        else value_mismatch("interrupt", '0, interrupt);
      pin_in = '0;               // falling edges set nothing
      wait_cycles(5);
      assert (interrupt == '0)
        else value_mismatch("interrupt", '0, interrupt);
    end

    // held stb, no second write or ack
    model_ov = 16'hA5C3;
    bus_access(1'b1, `GPR_OUTPUT_VALUE, model_ov, 3, rd);
    expect_reg(`GPR_OUTPUT_VALUE, model_ov, "dat_r output_value");
    bus_access(1'b0, `GPR_DIRECTION_MODE, '0, 3, rd);
    assert (rd == model_dir)
      else value_mismatch("dat_r direction_mode", model_dir, rd);
    check_pins();

    $display("tb_gpio: %0d value errors, %0d protocol errors", value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0)
    begin
      $display("Regression passed");
    end
    else
    begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+src
src/gpio_pkg.sv
src/gpio_pin_unit.sv
src/gpio_bus_fsm.sv
src/gpio_top.sv
bench/tb_gpio.sv

// File: run.sh
#!/bin/sh
# compile and run the gpio testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_gpio -f verilog.f

out=$(./obj_dir/Vtb_gpio)
echo "$out"

if echo "$out" | grep -q "^Regression passed$"; then
  exit 0
else
  exit 1
fi
